// ==== rtl/mvm_axil_slave.sv ====
/*
  Single-beat AXI-Lite slave. Every access is a full word, wstrb is not used.
  Host must hold each valid until the matching ready is seen.
  Reads of data_addr step through the four result words in rotation.
*/
`default_nettype none

module mvm_axil_slave (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  input  mvm_pkg::axil_req_t axil_req,
  output mvm_pkg::axil_rsp_t axil_rsp,
  input  logic               busy,
  input  mvm_pkg::vec_t      result,
  output mvm_pkg::load_wr_t  load_wr
);
  import mvm_pkg::*;

  logic                         wr_active;
  logic [addr_w-1:0]            wr_addr;
  logic                         wr_strobe;
  logic                         bvalid;
  logic                         arready;
  logic                         ar_accept;
  logic                         arvalid_q;
  logic [addr_w-1:0]            araddr_q;
  logic                         rvalid;
  logic [word_w-1:0]            rdata;
  logic [word_w-1:0]            rd_word;
  logic [$clog2(vec_words)-1:0] rd_ptr;
  logic [word_w-1:0]            scratch;

  // --------------------
  // Write channel
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (wr_active && bvalid && axil_req.bready) begin
      wr_active <= 1'b0;
    end else if (!wr_active && axil_req.awvalid) begin
      wr_active <= 1'b1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!wr_active && axil_req.awvalid) begin
      wr_addr <= axil_req.awaddr;
    end
  end

  // Data is taken the cycle wready goes high
  assign wr_strobe = wr_active && axil_req.wvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && axil_req.bready) begin
      bvalid <= 1'b0;
    end else if (wr_strobe) begin
      bvalid <= 1'b1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      scratch <= '0;
    end else if (wr_strobe && (wr_addr == scratch_addr)) begin
      scratch <= axil_req.wdata;
    end
  end

  // Operand and trigger words go on to the buffer
  assign load_wr.valid = wr_strobe && (wr_addr == data_addr);
  assign load_wr.word  = axil_req.wdata;

  // --------------------
  // Read channel
  // --------------------
  assign arready   = !arvalid_q && !rvalid;
  assign ar_accept = axil_req.arvalid && arready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      arvalid_q <= 1'b0;
    end else begin
      arvalid_q <= ar_accept;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_accept) begin
      araddr_q <= axil_req.araddr;
    end
  end

  // Read decode on the registered address
  always_comb begin
    case (araddr_q)
      data_addr:    rd_word = result[rd_ptr * (word_w / elem_w) +: (word_w / elem_w)];
      status_addr:  rd_word = {{(word_w - 1){1'b0}}, busy};
      scratch_addr: rd_word = scratch;
      default:      rd_word = unimpl_value;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
      rd_ptr <= '0;
    end else if (rvalid && axil_req.rready) begin
      rvalid <= 1'b0;
    end else if (arvalid_q) begin
      rvalid <= 1'b1;
      // Wraps after word 3
      if (araddr_q == data_addr) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid_q) begin
      rdata <= rd_word;
    end
  end

  // --------------------
  // Response outputs
  // --------------------
  assign axil_rsp.awready = !wr_active;
  assign axil_rsp.wready  = wr_strobe;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = 2'b00;
  assign axil_rsp.arready = arready;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = 2'b00;

endmodule

`default_nettype wire

// ==== rtl/mvm_engine.sv ====
/*
  Sequential matrix-vector engine, one 8-bit multiply-accumulate per clock.
  Each iteration takes 256 MAC cycles and one write-back cycle.
  Start is ignored while busy. Result is valid once busy falls.
*/
`default_nettype none

module mvm_engine (
  input  logic          clk_main_a0,
  input  logic          rst_main_n_sync,
  input  logic          start,
  input  logic [31:0]   iter_count,
  input  mvm_pkg::mat_t mat,
  input  mvm_pkg::vec_t vec,
  output logic          busy,
  output mvm_pkg::vec_t result
);
  import mvm_pkg::*;

  logic [$clog2(dim)-1:0] row;
  logic [$clog2(dim)-1:0] col;
  logic [31:0]            iters_left;
  logic                   write_back;
  logic                   last_col;
  logic                   last_row;
  logic                   mac_step;
  logic                   launch;
  vec_t                   work_vec;
  vec_t                   next_vec;
  elem_t                  product;
  elem_t                  partial;

  assign launch   = start && !busy;
  assign last_col = col == (dim - 1);
  assign last_row = row == (dim - 1);
  assign mac_step = busy && !write_back && (iters_left != 0);

  // --------------------
  // MAC datapath
  // --------------------
  // 8-bit context keeps the product modulo 256
  assign product = work_vec[col] * mat[row][col];
  assign partial = (col == 0) ? product : next_vec[row] + product;

  always_ff @(posedge clk_main_a0) begin
    if (launch) begin
      work_vec <= vec;
    end else if (busy && write_back) begin
      work_vec <= next_vec;
    end
    if (mac_step) begin
      next_vec[row] <= partial;
    end
  end

  // --------------------
  // Sequencing
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      busy       <= 1'b0;
      write_back <= 1'b0;
      row        <= '0;
      col        <= '0;
      iters_left <= '0;
      result     <= '0;
    end else if (!busy) begin
      if (start) begin
        busy       <= 1'b1;
        write_back <= 1'b0;
        row        <= '0;
        col        <= '0;
        iters_left <= iter_count;
      end
    end else if (iters_left == 0) begin
      // Zero count, loaded vector goes straight out
      result <= work_vec;
      busy   <= 1'b0;
    end else if (write_back) begin
      write_back <= 1'b0;
      iters_left <= iters_left - 1'b1;
      if (iters_left == 1) begin
        result <= next_vec;
        busy   <= 1'b0;
      end
    end else begin
      // Column inner loop, row outer loop
      col <= col + 1'b1;
      if (last_col) begin
        row <= row + 1'b1;
        if (last_row) begin
          write_back <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mvm_operand_buffer.sv ====
/*
  Collects 64 matrix words, 4 vector words and one trigger word, in that order.
  Words that arrive while the engine is busy are dropped and do not move
  the load index. Matrix and vector hold still for the whole run.
*/
`default_nettype none

module mvm_operand_buffer (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  mvm_pkg::load_wr_t load_wr,
  input  logic              busy,
  output mvm_pkg::mat_t     mat,
  output mvm_pkg::vec_t     vec,
  output logic              start,
  output logic [31:0]       iter_count
);
  import mvm_pkg::*;

  logic [$clog2(mat_words + vec_words + 1)-1:0] load_idx;
  logic                                         load_en;
  logic                                         in_mat;
  logic                                         is_trig;
  logic [$clog2(dim)-1:0]                       row_sel;
  logic [$clog2(dim)-1:0]                       lane_base;

  assign load_en = load_wr.valid && !busy;
  assign in_mat  = load_idx < mat_words;
  assign is_trig = load_idx == (mat_words + vec_words);

  // Four words per row, four lanes per word
  assign row_sel   = load_idx[$clog2(mat_words)-1:2];
  assign lane_base = {load_idx[1:0], 2'b00};

  // --------------------
  // Load sequencing
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      load_idx <= '0;
      start    <= 1'b0;
    end else begin
      start <= 1'b0;
      if (load_en) begin
        if (is_trig) begin
          load_idx <= '0;
          start    <= 1'b1;
        end else begin
          load_idx <= load_idx + 1'b1;
        end
      end
    end
  end

  // --------------------
  // Operand storage
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (load_en) begin
      if (in_mat) begin
        mat[row_sel][lane_base +: (word_w / elem_w)] <= load_wr.word.lanes;
      end else if (!is_trig) begin
        // Vector words follow at index 64..67
        vec[lane_base +: (word_w / elem_w)] <= load_wr.word.lanes;
      end else begin
        iter_count <= load_wr.word.count;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mvm_pkg.sv ====
/*
  Shared sizes, register map and types for the matrix-vector multiplier.
  Elements are unsigned 8-bit and all arithmetic wraps modulo 256.
  Element i of a vector sits in word i/4, byte i%4, low byte first.
*/
`default_nettype none

package mvm_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int dim       = 16;
  localparam int elem_w    = 8;
  localparam int word_w    = 32;
  localparam int addr_w    = 32;
  localparam int mat_words = 64;
  localparam int vec_words = 4;

  // --------------------
  // Register map
  // --------------------
  localparam logic [addr_w-1:0] data_addr    = 32'h0000_0500;
  localparam logic [addr_w-1:0] status_addr  = 32'h0000_0504;
  localparam logic [addr_w-1:0] scratch_addr = 32'h0000_0548;
  localparam logic [word_w-1:0] unimpl_value = 32'hdead_beef;

  // --------------------
  // Types
  // --------------------
  typedef logic [elem_w-1:0] elem_t;
  typedef elem_t [dim-1:0]   vec_t;
  // Row r, column c lands at flat element 16r+c
  typedef vec_t [dim-1:0]    mat_t;

  // Operand words carry four lanes, the trigger word carries the count
  typedef union packed {
    elem_t [word_w/elem_w-1:0] lanes;
    logic [word_w-1:0]         count;
  } load_word_u;

  typedef struct packed {
    logic              awvalid;
    logic [addr_w-1:0] awaddr;
    logic              wvalid;
    logic [word_w-1:0] wdata;
    logic              bready;
    logic              arvalid;
    logic [addr_w-1:0] araddr;
    logic              rready;
  } axil_req_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [word_w-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic       valid;
    load_word_u word;
  } load_wr_t;

endpackage

`default_nettype wire

// ==== rtl/mvm_top.sv ====
/*
  Matrix-vector multiplier behind an AXI-Lite register port.
  Reset arrives already synchronized to clk_main_a0.
*/
`default_nettype none

module mvm_top (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  input  mvm_pkg::axil_req_t axil_req,
  output mvm_pkg::axil_rsp_t axil_rsp
);
  import mvm_pkg::*;

  load_wr_t    load_wr;
  mat_t        mat;
  vec_t        vec;
  logic        start;
  logic [31:0] iter_count;
  logic        busy;
  vec_t        result;

  // --------------------
  // Register port
  // --------------------
  mvm_axil_slave u_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil_req        (axil_req),
    .axil_rsp        (axil_rsp),
    .busy            (busy),
    .result          (result),
    .load_wr         (load_wr)
  );

  // --------------------
  // Operand loading
  // --------------------
  mvm_operand_buffer u_buffer (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .load_wr         (load_wr),
    .busy            (busy),
    .mat             (mat),
    .vec             (vec),
    .start           (start),
    .iter_count      (iter_count)
  );

  // --------------------
  // Compute
  // --------------------
  mvm_engine u_engine (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .start           (start),
    .iter_count      (iter_count),
    .mat             (mat),
    .vec             (vec),
    .busy            (busy),
    .result          (result)
  );

endmodule

`default_nettype wire

// ==== verification/mvm_tb_tasks.svh ====
/*
  Bus tasks, reference model, compare tasks and directed tests.
  Every task starts and returns 1 ns after a rising edge.
*/
`ifndef MVM_TB_TASKS_SVH
`define MVM_TB_TASKS_SVH

localparam int flag_aw = 0;
localparam int flag_w  = 1;
localparam int flag_b  = 2;
localparam int flag_ar = 3;
localparam int flag_r  = 4;
localparam int max_cycles = 100;
localparam int max_polls  = 1000;

task automatic report_and_stop(input string line);
  $display("%s", line);
  $display("Test failed");
  $fatal(1);
endtask

function automatic logic rsp_flag(input int sel);
  logic [4:0] flags;
  flags = {axil_rsp.rvalid, axil_rsp.arready, axil_rsp.bvalid, axil_rsp.wready,
           axil_rsp.awready};
  return flags[sel];
endfunction

// Returns just after the edge that completes the handshake
task automatic wait_rsp(input int sel, input string what);
  int cycles;
  cycles = 0;
  @(negedge clk_main_a0);
  while (!rsp_flag(sel)) begin
    cycles++;
    if (cycles > max_cycles)
      report_and_stop($sformatf("Timeout: %s never came high", what));
    @(negedge clk_main_a0);
  end
  @(posedge clk_main_a0);
  #1;
endtask

// --------------------
// Bus access
// --------------------
task automatic write_word(input logic [addr_w-1:0] addr, input logic [word_w-1:0] data);
  axil_req.awvalid = 1'b1;
  axil_req.awaddr  = addr;
  axil_req.wvalid  = 1'b1;
  axil_req.wdata   = data;
  axil_req.bready  = 1'b1;
  wait_rsp(flag_aw, "awready");
  axil_req.awvalid = 1'b0;
  wait_rsp(flag_w, "wready");
  axil_req.wvalid = 1'b0;
  wait_rsp(flag_b, "bvalid");
  axil_req.bready = 1'b0;
  // Write response is always OKAY
  check_word("write response", 32'd0, {{(word_w - 2){1'b0}}, axil_rsp.bresp});
endtask

task automatic read_word(input logic [addr_w-1:0] addr, output logic [word_w-1:0] data);
  axil_req.arvalid = 1'b1;
  axil_req.araddr  = addr;
  axil_req.rready  = 1'b1;
  wait_rsp(flag_ar, "arready");
  axil_req.arvalid = 1'b0;
  wait_rsp(flag_r, "rvalid");
  data            = axil_rsp.rdata;
  axil_req.rready = 1'b0;
  check_word("read response", 32'd0, {{(word_w - 2){1'b0}}, axil_rsp.rresp});
  if (addr == data_addr)
    data_reads++;
endtask

task automatic wait_idle();
  logic [word_w-1:0] status;
  int                polls;
  polls = 0;
  read_word(status_addr, status);
  while (status[0]) begin
    polls++;
    if (polls > max_polls)
      report_and_stop("Timeout: engine stayed busy");
    read_word(status_addr, status);
  end
endtask

// Rotation pointer advances once per data read, modulo 4
task automatic read_result(output vec_t res);
  logic [word_w-1:0] word;
  int                idx;
  res = '0;
  repeat (vec_words) begin
    idx = data_reads % vec_words;
    read_word(data_addr, word);
    res[idx*4 +: 4] = word;
  end
endtask

task automatic load_operands(input mat_t m, input vec_t v, input int unsigned count);
  logic [dim*dim*elem_w-1:0] flat;
  logic [dim*elem_w-1:0]     vflat;
  int                        w;
  flat  = m;
  vflat = v;
  for (w = 0; w < mat_words; w++)
    write_word(data_addr, flat[w*word_w +: word_w]);
  for (w = 0; w < vec_words; w++)
    write_word(data_addr, vflat[w*word_w +: word_w]);
  write_word(data_addr, count);
endtask

task automatic run_operands(input mat_t m, input vec_t v, input int unsigned count,
                            output vec_t got);
  load_operands(m, v, count);
  wait_idle();
  read_result(got);
endtask

// --------------------
// Model and checks
// --------------------
function automatic vec_t model_run(input mat_t m, input vec_t v, input int unsigned count);
  vec_t        cur;
  vec_t        nxt;
  int unsigned sum;
  cur = v;
  for (int unsigned it = 0; it < count; it++) begin
    for (int j = 0; j < dim; j++) begin
      sum = 0;
      for (int k = 0; k < dim; k++)
        sum = sum + m[j][k] * cur[k];
      nxt[j] = elem_t'(sum % 256);
    end
    cur = nxt;
  end
  return cur;
endfunction

task automatic random_operands(output mat_t m, output vec_t v);
  logic [dim*dim*elem_w-1:0] flat;
  logic [dim*elem_w-1:0]     vflat;
  int                        w;
  for (w = 0; w < mat_words; w++)
    flat[w*word_w +: word_w] = $random(seed);
  for (w = 0; w < vec_words; w++)
    vflat[w*word_w +: word_w] = $random(seed);
  m = flat;
  v = vflat;
endtask

task automatic check_word(input string name, input logic [word_w-1:0] exp,
                          input logic [word_w-1:0] act);
  if (act !== exp)
    report_and_stop($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_vec(input string name, input vec_t exp, input vec_t act);
  if (act !== exp)
    report_and_stop($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
endtask

// --------------------
// Directed tests
// --------------------
task automatic scratch_readback();
  logic [word_w-1:0] val;
  logic [word_w-1:0] got;
  val = $random(seed);
  write_word(scratch_addr, val);
  read_word(scratch_addr, got);
  check_word("scratch", val, got);
  read_word(32'h0000_0600, got);
  check_word("unmapped read", unimpl_value, got);
endtask

task automatic identity_run();
  mat_t m;
  vec_t v;
  vec_t got;
  random_operands(m, v);
  m = '0;
  for (int r = 0; r < dim; r++)
    m[r][r] = 8'd1;
  run_operands(m, v, 1, got);
  check_vec("identity", v, got);
endtask

task automatic multi_iteration_run();
  mat_t m;
  vec_t v;
  vec_t got;
  random_operands(m, v);
  run_operands(m, v, 3, got);
  check_vec("random count 3", model_run(m, v, 3), got);
endtask

task automatic zero_count_run();
  mat_t m;
  vec_t v;
  vec_t got;
  random_operands(m, v);
  run_operands(m, v, 0, got);
  check_vec("zero count", v, got);
endtask

task automatic busy_discard();
  mat_t              m;
  vec_t              v;
  vec_t              got;
  logic [word_w-1:0] status;
  random_operands(m, v);
  load_operands(m, v, 2);
  read_word(status_addr, status);
  check_word("busy status", 32'd1, status);
  repeat (5) write_word(data_addr, $random(seed));
  wait_idle();
  read_result(got);
  check_vec("busy discard", model_run(m, v, 2), got);
  // A full reload must start again at matrix word 0
  random_operands(m, v);
  run_operands(m, v, 1, got);
  last_result = model_run(m, v, 1);
  check_vec("reload after discard", last_result, got);
endtask

task automatic read_rotation();
  logic [word_w-1:0] got;
  int                idx;
  for (int i = 0; i < 2 * vec_words; i++) begin
    idx = data_reads % vec_words;
    read_word(data_addr, got);
    check_word($sformatf("rotation read %0d", i), last_result[idx*4 +: 4], got);
  end
endtask

`endif

// ==== verification/tb_mvm_top.sv ====
/*
  Directed testbench for mvm_top over its AXI-Lite port.
  Inputs change 1 ns after the rising edge, outputs are sampled at the falling edge.
  The first failing check or expired wait ends the run.
*/
`default_nettype none

module tb_mvm_top;
  timeunit 1ns;
  timeprecision 100ps;
  import mvm_pkg::*;

  localparam int clk_half = 4;

  logic      clk_main_a0;
  logic      rst_main_n_sync;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  int        seed;
  int        data_reads;
  vec_t      last_result;

  mvm_top uut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil_req        (axil_req),
    .axil_rsp        (axil_rsp)
  );

  `include "mvm_tb_tasks.svh"

  initial begin
    clk_main_a0 = 1'b0;
    forever #clk_half clk_main_a0 = ~clk_main_a0;
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    seed            = 32'hc7b9;
    data_reads      = 0;
    last_result     = '0;
    axil_req        = '0;
    rst_main_n_sync = 1'b0;
    repeat (4) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
    scratch_readback();
    identity_run();
    multi_iteration_run();
    zero_count_run();
    busy_discard();
    // Relies on last_result from the run before
    read_rotation();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verification
rtl/mvm_pkg.sv
rtl/mvm_axil_slave.sv
rtl/mvm_operand_buffer.sv
rtl/mvm_engine.sv
rtl/mvm_top.sv
verification/tb_mvm_top.sv
